// File: tb/mips_cases.mem
// Header: word count, expected v0, store address, expected store word, cycle budget
// Then the program words, loaded at bfc00000; a zero count ends the list
// ALU register forms, v0 = fffffedd
00000009 fffffedd ffffffff 00000000 00000040
24080123 2409fffe 01095021  // addiu t0 0x123, addiu t1 -2, addu t2
01495823 012b6024 018a6825  // subu t3, and t4, or t5
01a91026                    // xor v0
00000008 00000000           // jr zero, nop
// SLT, SLTU, shifts, LUI/ORI and immediates, v0 = 008000e1
0000000e 008000e1 ffffffff 00000000 00000040
3c088000 35080010 24090005  // lui t0, ori t0, addiu t1 5
0109502a 0109582b           // slt t2, sltu t3
000a6100 00086a02 292e0006  // sll t4 4, srl t5 8, slti t6
018d7825 01ee7821 01eb7821  // or t7, addu t7 t6, addu t7 t3
39e200f0                    // xori v0
00000008 00000000           // jr zero, nop
// SW then SB at 0x42, LW and LBU read back, v0 = 0000ab34
0000000c 0000ab34 00000042 abababab 00000040
24040040 3c081234 35085678  // addiu a0 0x40, lui/ori t0 12345678
ac880000 240900ab a0890002  // sw t0, addiu t1 ab, sb t1 2(a0)
8c8a0000 908b0001           // lw t2, lbu t3 1(a0)
314cff00 018b1021           // andi t4 ff00, addu v0
00000008 00000000           // jr zero, nop
// BEQ/BNE taken and not taken with delay slots, v0 = 00000073
0000000f 00000073 ffffffff 00000000 00000040
24080003 24090003           // addiu t0 3, addiu t1 3
11090002 24020010 24420100  // beq taken, slot +10, skipped +100
15090002 24420001 24420002  // bne not taken, slot +1, then +2
15000002 24420020 24420400  // bne taken, slot +20, skipped +400
11000001 24420040           // beq not taken, slot +40
00000008 00000000           // jr zero, nop
// JAL into a subroutine, JR ra back, J forward, store ra at 0x80, v0 = 00000160
0000000c 00000160 00000080 bfc0000c 00000040
24020001 0ff00006 24420002  // addiu v0 1, jal sub, slot +2
24420010 0bf00009 24420020  // +10 after return, j end, slot +20
00021100 03e00008 24420100  // sub sll v0 4, jr ra, slot +100
ac1f0080                    // end sw ra 0x80
00000008 00000000           // jr zero, nop
00000000

// File: tb.f
rtl/mips_pkg.sv
rtl/mips_control.sv
rtl/mips_regfile.sv
rtl/mips_alu.sv
rtl/mips_next_pc.sv
rtl/mips_mem_lanes.sv
rtl/mips_cpu_harvard.sv
tb/mips_tb_memory.sv
tb/mips_cpu_harvard_tb.sv

// File: tb/mips_cpu_harvard_tb.sv
`timescale 1ns/1ps

module mips_cpu_harvard_tb;

  logic        clk = 1'b0;
  logic        reset = 1'b1;
  logic        clk_enable = 1'b0;
  logic        active;
  logic [31:0] register_v0;
  logic [31:0] instr_address;
  logic [31:0] instr_readdata;
  logic [31:0] data_address;
  logic        data_write;
  logic        data_read;
  logic [31:0] data_writedata;
  logic [31:0] data_readdata;
  logic        rom_write = 1'b0;
  logic [5:0]  rom_index = 6'd0;
  logic [31:0] rom_data = 32'd0;

  logic [31:0] cases [256];
  logic [15:0] lfsr_state = 16'd90;
  int          budget_total = 0;
  int          watchdog_ns = 0;

  // 10 ns clock
  always #5 clk = ~clk;

  mips_cpu_harvard UUT (
    .clk(clk), .reset(reset), .active(active), .register_v0(register_v0),
    .clk_enable(clk_enable), .instr_address(instr_address),
    .instr_readdata(instr_readdata), .data_address(data_address),
    .data_write(data_write), .data_read(data_read),
    .data_writedata(data_writedata), .data_readdata(data_readdata)
  );

  mips_tb_memory memories (
    .clk(clk), .reset(reset), .clk_enable(clk_enable), .rom_write(rom_write),
    .rom_index(rom_index), .rom_data(rom_data), .instr_address(instr_address),
    .instr_readdata(instr_readdata), .data_address(data_address),
    .data_write(data_write), .data_read(data_read),
    .data_writedata(data_writedata), .data_readdata(data_readdata)
  );

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected)
    begin
      stop_with_failure($sformatf("CHECK FAILED at %0t: %s is %h, expected %h",
                                  $time, name, actual, expected));
    end
  endtask

  // 16-bit Galois LFSR with maximal-length taps
  function automatic logic [15:0] lfsr_step(input logic [15:0] state);
    logic [15:0] shifted;
    shifted = state >> 1;
    if (state[0])
      shifted = shifted ^ 16'hb400;
    return shifted;
  endfunction

  task automatic draw_bit(output logic value);
    value = lfsr_state[0];
    lfsr_state = lfsr_step(lfsr_state);
  endtask

  // Header words are count, v0, store address, store word and budget
  task automatic run_case(input int base, input int number);
    int          count;
    int          i;
    logic [31:0] store_addr;
    logic [31:0] store_word;
    logic [31:0] held_addr;
    logic        bit_a;
    logic        bit_b;
    logic        is_load;
    count = cases[base];
    $display("Case %0d, %0d instructions", number, count);

    // Program goes into the ROM while the core sits in reset
    @(negedge clk);
    reset = 1'b1;
    clk_enable = 1'b1;

    // Store and then load at the reset vector must stay off the bus in reset
    rom_write = 1'b1;
    rom_index = 6'd0;
    rom_data = {mips_pkg::op_sw, 26'd0};
    @(negedge clk);
    check_value("data_write", {31'd0, data_write}, 32'd0);
    rom_data = {mips_pkg::op_lw, 26'd0};
    @(negedge clk);
    check_value("data_read", {31'd0, data_read}, 32'd0);

    for (i = 0; i < count; i++)
    begin
      rom_write = 1'b1;
      rom_index = 6'(i);
      rom_data = cases[base + 5 + i];
      @(negedge clk);
    end
    rom_write = 1'b0;
    repeat (5) @(negedge clk);

    // Reset state
    check_value("instr_address", instr_address, mips_pkg::reset_vector);
    check_value("active", {31'd0, active}, 32'd1);

    reset = 1'b0;
    store_addr = 32'hffff_ffff;
    store_word = 32'd0;
    while (active)
    begin
      // Enable high unless both random bits are zero
      draw_bit(bit_a);
      draw_bit(bit_b);
      clk_enable = bit_a | bit_b;
      held_addr = instr_address;

      // Only LW and LBU read data memory
      is_load = (instr_readdata[31:26] == mips_pkg::op_lw)
                || (instr_readdata[31:26] == mips_pkg::op_lbu);
      check_value("data_read", {31'd0, data_read}, {31'd0, is_load});

      // Store lands at the coming edge when enabled
      if (clk_enable && data_write)
      begin
        store_addr = data_address;
        store_word = data_writedata;
      end
      @(negedge clk);
      // Stalled cycle leaves the PC alone
      if (!clk_enable)
        check_value("instr_address", instr_address, held_addr);
    end

    check_value("instr_address", instr_address, 32'd0);
    check_value("register_v0", register_v0, cases[base + 1]);
    check_value("data_address", store_addr, cases[base + 2]);
    check_value("data_writedata", store_word, cases[base + 3]);
  endtask

  // Ends the run if the cases take longer than their summed budget allows
  initial
  begin
    wait (watchdog_ns != 0);
    #(watchdog_ns);
    stop_with_failure("Timeout, the test cases ran past their cycle budget");
  end

  initial
  begin
    int pos;
    int number;
    $readmemh("tb/mips_cases.mem", cases);

    // Sum of budgets up to the zero count that ends the file
    pos = 0;
    while (pos < 252 && !$isunknown(cases[pos]) && cases[pos] != 32'd0)
    begin
      budget_total += cases[pos + 4];
      pos += 5 + cases[pos];
    end

    if (budget_total == 0)
      stop_with_failure("No test cases could be read from tb/mips_cases.mem");
    else
    begin
      // Four times the budget leaves room for stalls
      watchdog_ns = budget_total * 4 * 10;
      pos = 0;
      number = 0;
      while (pos < 252 && !$isunknown(cases[pos]) && cases[pos] != 32'd0)
      begin
        number++;
        run_case(pos, number);
        pos += 5 + cases[pos];
      end

      $display("Finished with no errors");
      $finish;
    end
  end

endmodule

// File: tb/mips_tb_memory.sv
`timescale 1ns/1ps

module mips_tb_memory (
  input  logic        clk,
  input  logic        reset,
  input  logic        clk_enable,
  input  logic        rom_write,
  input  logic [5:0]  rom_index,
  input  logic [31:0] rom_data,
  input  logic [31:0] instr_address,
  output logic [31:0] instr_readdata,
  input  logic [31:0] data_address,
  input  logic        data_write,
  input  logic        data_read,
  input  logic [31:0] data_writedata,
  output logic [31:0] data_readdata
);

  logic [31:0] rom [64];
  logic [31:0] ram [64];
  logic [31:0] rom_offset;
  logic [5:0]  ram_index;

  // 64-word ROM window starting at the reset vector
  assign rom_offset = instr_address - mips_pkg::reset_vector;

  // Fetches outside the window read as NOP
  assign instr_readdata = (rom_offset < 32'd256) ? rom[rom_offset[7:2]] : 32'd0;

  // RAM covers byte addresses 0x00 to 0xff
  assign ram_index     = data_address[7:2];
  assign data_readdata = data_read ? ram[ram_index] : 32'd0;

  always @(posedge clk)
  begin
    // Program load port, used while the core is held in reset
    if (rom_write)
      rom[rom_index] <= rom_data;

    if (reset)
    begin
      // Known fill, each word holds 5a5a00 plus its own byte address
      for (int i = 0; i < 64; i++)
        ram[i] <= {24'h5a5a00, 6'(i), 2'b00};
    end
    else if (clk_enable && data_write)
    begin
      if (instr_readdata[31:26] == mips_pkg::op_sb)
      begin
        // SB writes only the addressed lane, big-endian
        case (data_address[1:0])
          2'd0:    ram[ram_index][31:24] <= data_writedata[31:24];
          2'd1:    ram[ram_index][23:16] <= data_writedata[23:16];
          2'd2:    ram[ram_index][15:8]  <= data_writedata[15:8];
          default: ram[ram_index][7:0]   <= data_writedata[7:0];
        endcase
      end
      else
        ram[ram_index] <= data_writedata;
    end
  end

endmodule

// File: rtl/mips_cpu_harvard.sv
`timescale 1ns/1ps

module mips_cpu_harvard (
  input  logic        clk,
  input  logic        reset,
  output logic        active,
  output logic [31:0] register_v0,

  input  logic        clk_enable,

  output logic [31:0] instr_address,
  input  logic [31:0] instr_readdata,

  output logic [31:0] data_address,
  output logic        data_write,
  output logic        data_read,
  output logic [31:0] data_writedata,
  input  logic [31:0] data_readdata
);

  mips_pkg::instr_u  instr;
  mips_pkg::alu_op_t alu_op;

  logic        reg_write;
  logic [1:0]  reg_dst;
  logic [1:0]  mem_to_reg;
  logic        alu_src_imm;
  logic        imm_zero_ext;
  logic        branch_eq;
  logic        branch_ne;
  logic        jump;
  logic        jump_reg;
  logic        mem_read;
  logic        mem_write;
  logic        byte_access;
  logic [31:0] rs_value;
  logic [31:0] rt_value;
  logic [31:0] alu_result;
  logic        operands_equal;
  logic [31:0] load_value;
  logic [31:0] link_address;
  logic [4:0]  write_index;
  logic [31:0] write_data;
  logic        running;

  assign instr = instr_readdata;

  // Nothing retires once the PC has hit the halt address
  assign running = active && (instr_address != 32'd0);

  assign data_address = alu_result;
  assign data_read    = mem_read && running && !reset;
  assign data_write   = mem_write && running && !reset;

  // Destination index
  always_comb
  begin
    case (reg_dst)
      mips_pkg::dst_rd: write_index = instr.r.rd;
      mips_pkg::dst_ra: write_index = mips_pkg::reg_ra;
      default:          write_index = instr.r.rt;
    endcase
  end

  // Write-back source
  always_comb
  begin
    case (mem_to_reg)
      mips_pkg::wb_load: write_data = load_value;
      mips_pkg::wb_link: write_data = link_address;
      default:           write_data = alu_result;
    endcase
  end

  mips_control control (
    .instr(instr), .reg_write(reg_write), .reg_dst(reg_dst), .mem_to_reg(mem_to_reg),
    .alu_op(alu_op), .alu_src_imm(alu_src_imm), .imm_zero_ext(imm_zero_ext),
    .branch_eq(branch_eq), .branch_ne(branch_ne), .jump(jump), .jump_reg(jump_reg),
    .mem_read(mem_read), .mem_write(mem_write), .byte_access(byte_access)
  );

  mips_regfile regfile (
    .clk(clk), .reset(reset), .enable(clk_enable), .write_enable(reg_write && running),
    .rs_index(instr.r.rs), .rt_index(instr.r.rt), .write_index(write_index),
    .write_data(write_data), .rs_value(rs_value), .rt_value(rt_value),
    .register_v0(register_v0)
  );

  mips_alu alu (
    .alu_op(alu_op), .shamt(instr.r.shamt), .imm16(instr.i.imm16),
    .alu_src_imm(alu_src_imm), .imm_zero_ext(imm_zero_ext), .rs_value(rs_value),
    .rt_value(rt_value), .alu_result(alu_result), .operands_equal(operands_equal)
  );

  mips_next_pc next_pc (
    .clk(clk), .reset(reset), .enable(clk_enable), .imm16(instr.i.imm16),
    .target26(instr.j.target26), .rs_value(rs_value), .branch_eq(branch_eq),
    .branch_ne(branch_ne), .jump(jump), .jump_reg(jump_reg),
    .operands_equal(operands_equal), .instr_address(instr_address),
    .link_address(link_address), .active(active)
  );

  mips_mem_lanes mem_lanes (
    .byte_access(byte_access), .address_low(alu_result[1:0]), .rt_value(rt_value),
    .data_readdata(data_readdata), .data_writedata(data_writedata),
    .load_value(load_value)
  );

endmodule

// File: rtl/mips_mem_lanes.sv
`timescale 1ns/1ps

module mips_mem_lanes (
  input  logic        byte_access,
  input  logic [1:0]  address_low,
  input  logic [31:0] rt_value,
  input  logic [31:0] data_readdata,
  output logic [31:0] data_writedata,
  output logic [31:0] load_value
);

  logic [7:0] load_byte;

  // SB puts the byte on every lane, memory picks the one addressed
  assign data_writedata = byte_access ? {4{rt_value[7:0]}} : rt_value;

  // Big-endian lanes, address 0 is the top byte
  always_comb
  begin
    case (address_low)
      2'd0:    load_byte = data_readdata[31:24];
      2'd1:    load_byte = data_readdata[23:16];
      2'd2:    load_byte = data_readdata[15:8];
      default: load_byte = data_readdata[7:0];
    endcase
  end

  // LBU zero-extends, LW takes the whole word
  assign load_value = byte_access ? {24'd0, load_byte} : data_readdata;

endmodule

// File: rtl/mips_next_pc.sv
`timescale 1ns/1ps

module mips_next_pc (
  input  logic        clk,
  input  logic        reset,
  input  logic        enable,
  input  logic [15:0] imm16,
  input  logic [25:0] target26,
  input  logic [31:0] rs_value,
  input  logic        branch_eq,
  input  logic        branch_ne,
  input  logic        jump,
  input  logic        jump_reg,
  input  logic        operands_equal,
  output logic [31:0] instr_address,
  output logic [31:0] link_address,
  output logic        active
);

  logic [31:0] pc;
  logic [31:0] pc_plus4;
  logic [31:0] target;
  logic [31:0] pending_target;
  logic        pending;
  logic        taken;

  assign instr_address = pc;
  assign pc_plus4      = pc + 32'd4;

  // Return lands after the delay slot
  assign link_address  = pc + 32'd8;

  assign taken = (branch_eq && operands_equal) || (branch_ne && !operands_equal)
                 || jump || jump_reg;

  always_comb
  begin
    if (jump_reg)
      target = rs_value;
    else if (jump)
      target = {pc_plus4[31:28], target26, 2'b00};
    else
      // Branch offset is word-scaled, relative to the delay slot
      target = pc_plus4 + {{14{imm16[15]}}, imm16, 2'b00};
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      pc      <= mips_pkg::reset_vector;
      pending <= 1'b0;
      active  <= 1'b1;
    end
    else if (enable && active)
    begin
      if (pc == 32'd0)
      begin
        // Halt, PC frozen at zero
        active <= 1'b0;
      end
      else
      begin
        pc      <= pending ? pending_target : pc_plus4;
        pending <= taken;
      end
    end
  end

  // Target held for one instruction while the delay slot runs
  always_ff @(posedge clk)
  begin
    if (enable && taken)
      pending_target <= target;
  end

endmodule

// File: rtl/mips_alu.sv
`timescale 1ns/1ps

module mips_alu (
  input  mips_pkg::alu_op_t alu_op,
  input  logic [4:0]        shamt,
  input  logic [15:0]       imm16,
  input  logic              alu_src_imm,
  input  logic              imm_zero_ext,
  input  logic [31:0]       rs_value,
  input  logic [31:0]       rt_value,
  output logic [31:0]       alu_result,
  output logic              operands_equal
);

  logic [31:0] imm_ext;
  logic [31:0] operand_b;

  // Logical immediates zero-extend, the rest sign-extend
  assign imm_ext   = imm_zero_ext ? {16'd0, imm16} : {{16{imm16[15]}}, imm16};
  assign operand_b = alu_src_imm ? imm_ext : rt_value;

  // BEQ/BNE compare the raw register values
  assign operands_equal = (rs_value == rt_value);

  always_comb
  begin
    case (alu_op)
      mips_pkg::alu_add:  alu_result = rs_value + operand_b;
      mips_pkg::alu_sub:  alu_result = rs_value - operand_b;
      mips_pkg::alu_and:  alu_result = rs_value & operand_b;
      mips_pkg::alu_or:   alu_result = rs_value | operand_b;
      mips_pkg::alu_xor:  alu_result = rs_value ^ operand_b;
      mips_pkg::alu_slt:
      begin
        alu_result = {31'd0, $signed(rs_value) < $signed(operand_b)};
      end
      mips_pkg::alu_sltu:
      begin
        alu_result = {31'd0, rs_value < operand_b};
      end
      // Shifts act on rt by shamt
      mips_pkg::alu_sll:  alu_result = rt_value << shamt;
      mips_pkg::alu_srl:  alu_result = rt_value >> shamt;
      // Immediate into the upper half
      mips_pkg::alu_lui:  alu_result = {imm16, 16'd0};
      default:            alu_result = 32'd0;
    endcase
  end

endmodule

// File: rtl/mips_regfile.sv
`timescale 1ns/1ps

module mips_regfile (
  input  logic        clk,
  input  logic        reset,
  input  logic        enable,
  input  logic        write_enable,
  input  logic [4:0]  rs_index,
  input  logic [4:0]  rt_index,
  input  logic [4:0]  write_index,
  input  logic [31:0] write_data,
  output logic [31:0] rs_value,
  output logic [31:0] rt_value,
  output logic [31:0] register_v0
);

  logic [31:0] regs [32];

  // Asynchronous reads
  assign rs_value = regs[rs_index];
  assign rt_value = regs[rt_index];

  // Debug tap on v0
  assign register_v0 = regs[mips_pkg::reg_v0];

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      for (int i = 0; i < 32; i++)
      begin
        regs[i] <= 32'd0;
      end
    end
    else if (enable && write_enable && (write_index != 5'd0))
    begin
      // r0 never written, stays zero
      regs[write_index] <= write_data;
    end
  end

endmodule

// File: rtl/mips_control.sv
`timescale 1ns/1ps

module mips_control (
  input  mips_pkg::instr_u  instr,
  output logic              reg_write,
  output logic [1:0]        reg_dst,
  output logic [1:0]        mem_to_reg,
  output mips_pkg::alu_op_t alu_op,
  output logic              alu_src_imm,
  output logic              imm_zero_ext,
  output logic              branch_eq,
  output logic              branch_ne,
  output logic              jump,
  output logic              jump_reg,
  output logic              mem_read,
  output logic              mem_write,
  output logic              byte_access
);

  always_comb
  begin
    // Defaults form a no-op
    reg_write    = 1'b0;
    reg_dst      = mips_pkg::dst_rt;
    mem_to_reg   = mips_pkg::wb_alu;
    alu_op       = mips_pkg::alu_add;
    alu_src_imm  = 1'b0;
    imm_zero_ext = 1'b0;
    branch_eq    = 1'b0;
    branch_ne    = 1'b0;
    jump         = 1'b0;
    jump_reg     = 1'b0;
    mem_read     = 1'b0;
    mem_write    = 1'b0;
    byte_access  = 1'b0;

    case (instr.r.opcode)
      mips_pkg::op_special:
      begin
        reg_dst   = mips_pkg::dst_rd;
        reg_write = 1'b1;
        case (instr.r.funct)
          mips_pkg::fn_addu: alu_op = mips_pkg::alu_add;
          mips_pkg::fn_subu: alu_op = mips_pkg::alu_sub;
          mips_pkg::fn_and:  alu_op = mips_pkg::alu_and;
          mips_pkg::fn_or:   alu_op = mips_pkg::alu_or;
          mips_pkg::fn_xor:  alu_op = mips_pkg::alu_xor;
          mips_pkg::fn_slt:  alu_op = mips_pkg::alu_slt;
          mips_pkg::fn_sltu: alu_op = mips_pkg::alu_sltu;
          mips_pkg::fn_sll:  alu_op = mips_pkg::alu_sll;
          mips_pkg::fn_srl:  alu_op = mips_pkg::alu_srl;
          mips_pkg::fn_jr:
          begin
            reg_write = 1'b0;
            jump_reg  = 1'b1;
          end
          // Unknown funct writes nothing
          default: reg_write = 1'b0;
        endcase
      end

      // Immediate ALU forms
      mips_pkg::op_addiu:
      begin
        reg_write   = 1'b1;
        alu_src_imm = 1'b1;
      end
      mips_pkg::op_slti:
      begin
        reg_write   = 1'b1;
        alu_src_imm = 1'b1;
        alu_op      = mips_pkg::alu_slt;
      end
      mips_pkg::op_andi, mips_pkg::op_ori, mips_pkg::op_xori:
      begin
        reg_write    = 1'b1;
        alu_src_imm  = 1'b1;
        imm_zero_ext = 1'b1;
        if (instr.r.opcode == mips_pkg::op_andi)
          alu_op = mips_pkg::alu_and;
        else if (instr.r.opcode == mips_pkg::op_ori)
          alu_op = mips_pkg::alu_or;
        else
          alu_op = mips_pkg::alu_xor;
      end
      mips_pkg::op_lui:
      begin
        reg_write = 1'b1;
        alu_op    = mips_pkg::alu_lui;
      end

      // Loads and stores, address = rs + sext(imm)
      mips_pkg::op_lw, mips_pkg::op_lbu:
      begin
        reg_write   = 1'b1;
        alu_src_imm = 1'b1;
        mem_to_reg  = mips_pkg::wb_load;
        mem_read    = 1'b1;
        byte_access = (instr.r.opcode == mips_pkg::op_lbu);
      end
      mips_pkg::op_sw, mips_pkg::op_sb:
      begin
        alu_src_imm = 1'b1;
        mem_write   = 1'b1;
        byte_access = (instr.r.opcode == mips_pkg::op_sb);
      end

      mips_pkg::op_beq: branch_eq = 1'b1;
      mips_pkg::op_bne: branch_ne = 1'b1;
      mips_pkg::op_j:   jump      = 1'b1;
      mips_pkg::op_jal:
      begin
        jump       = 1'b1;
        reg_write  = 1'b1;
        reg_dst    = mips_pkg::dst_ra;
        mem_to_reg = mips_pkg::wb_link;
      end
      default: ;
    endcase
  end

endmodule

// File: rtl/mips_pkg.sv
package mips_pkg;

  // Primary opcodes, instr[31:26]
  localparam logic [5:0] op_special = 6'h00;
  localparam logic [5:0] op_j       = 6'h02;
  localparam logic [5:0] op_jal     = 6'h03;
  localparam logic [5:0] op_beq     = 6'h04;
  localparam logic [5:0] op_bne     = 6'h05;
  localparam logic [5:0] op_addiu   = 6'h09;
  localparam logic [5:0] op_slti    = 6'h0a;
  localparam logic [5:0] op_andi    = 6'h0c;
  localparam logic [5:0] op_ori     = 6'h0d;
  localparam logic [5:0] op_xori    = 6'h0e;
  localparam logic [5:0] op_lui     = 6'h0f;
  localparam logic [5:0] op_lw      = 6'h23;
  localparam logic [5:0] op_lbu     = 6'h24;
  localparam logic [5:0] op_sb      = 6'h28;
  localparam logic [5:0] op_sw      = 6'h2b;

  // SPECIAL funct codes, instr[5:0]
  localparam logic [5:0] fn_sll  = 6'h00;
  localparam logic [5:0] fn_srl  = 6'h02;
  localparam logic [5:0] fn_jr   = 6'h08;
  localparam logic [5:0] fn_addu = 6'h21;
  localparam logic [5:0] fn_subu = 6'h23;
  localparam logic [5:0] fn_and  = 6'h24;
  localparam logic [5:0] fn_or   = 6'h25;
  localparam logic [5:0] fn_xor  = 6'h26;
  localparam logic [5:0] fn_slt  = 6'h2a;
  localparam logic [5:0] fn_sltu = 6'h2b;

  // Boot ROM base
  localparam logic [31:0] reset_vector = 32'hbfc0_0000;

  // Fixed register indices
  localparam logic [4:0] reg_v0 = 5'd2;
  localparam logic [4:0] reg_ra = 5'd31;

  // Destination register select
  localparam logic [1:0] dst_rt = 2'd0;
  localparam logic [1:0] dst_rd = 2'd1;
  localparam logic [1:0] dst_ra = 2'd2;

  // Write-back source select
  localparam logic [1:0] wb_alu  = 2'd0;
  localparam logic [1:0] wb_load = 2'd1;
  localparam logic [1:0] wb_link = 2'd2;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt,
    alu_sltu,
    alu_sll,
    alu_srl,
    alu_lui
  } alu_op_t;

  typedef struct packed {
    logic [5:0] opcode;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt;
    logic [5:0] funct;
  } r_format_t;

  typedef struct packed {
    logic [5:0]  opcode;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] imm16;
  } i_format_t;

  typedef struct packed {
    logic [5:0]  opcode;
    logic [25:0] target26;
  } j_format_t;

  // Same instruction word seen as R, I or J format
  typedef union packed {
    r_format_t r;
    i_format_t i;
    j_format_t j;
  } instr_u;

endpackage
